/* vlog.f */
hdl/nora_pkg.sv
hdl/cpu_phaser.sv
hdl/bus_tracer.sv
hdl/trace_fifo.sv
hdl/icd_controller.sv
hdl/nora_top.sv
dv/tb_clkgen.sv
dv/tb_top.sv

/* Bender.yml */
package:
  name: nora_cpu_bus

sources:
  - files:
      - hdl/nora_pkg.sv
      - hdl/cpu_phaser.sv
      - hdl/bus_tracer.sv
      - hdl/trace_fifo.sv
      - hdl/icd_controller.sv
      - hdl/nora_top.sv
  - target: test
    files:
      - dv/tb_clkgen.sv
      - dv/tb_top.sv

/* dv/tb_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench top: CPU-bus model, host command driver, checking assertions
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_top
    import nora_pkg::*;
();

    localparam int FIFO_DEPTH  = 8;
    localparam int TIMEOUT     = 200;  // clk6x ticks allowed per wait
    localparam int QUIET_TICKS = 20;   // Window for the empty read

    logic              clk6x;
    logic              rst;
    logic [ADDR_W-1:0] cpu_ab;
    logic [DATA_W-1:0] cpu_db;
    logic [DATA_W-1:0] cpu_status;
    logic              cmd_valid;
    icd_cmd_e          cmd;
    logic              cphi2;
    logic              stopped;
    logic              busy;
    logic [DATA_W-1:0] rd_byte;
    logic              rd_valid;

    integer            seed = 32'he53e_e645;
    logic [31:0]       bus_q [$];          // {address, data, status} per finished cycle
    logic              phi2_last;
    logic              expect_rx;          // Host port may talk
    logic [DATA_W-1:0] rx_bytes [TRACE_BYTES];
    logic [DATA_W-1:0] next_seq;           // Predicted sequence number
    int                error_count;

    tb_clkgen u_clkgen (
        .clk6x (clk6x),
        .rst_o (rst)
    );

    nora_top #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) uut (
        .clk6x        (clk6x),
        .rst_i        (rst),
        .cpu_ab_i     (cpu_ab),
        .cpu_db_i     (cpu_db),
        .cpu_status_i (cpu_status),
        .cmd_valid_i  (cmd_valid),
        .cmd_i        (cmd),
        .cphi2_o      (cphi2),
        .stopped_o    (stopped),
        .busy_o       (busy),
        .rd_byte_o    (rd_byte),
        .rd_valid_o   (rd_valid)
    );

    task automatic fail_now(input string msg);
        error_count++;
        $display("%s", msg);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_value(input string test, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected)
        else
        begin
            fail_now($sformatf("MISMATCH %s: expected 0x%0h actual 0x%0h",
                               test, expected, actual));
        end
    endtask

    // One draw feeds the whole bus
    task automatic draw_bus_values();
        logic [31:0] rnd;
        rnd        = $random(seed);
        cpu_ab     = rnd[15:0];
        cpu_db     = rnd[23:16];
        cpu_status = rnd[31:24];
    endtask

    // CPU-bus model, new values once the CPU clock has fallen
    always @(negedge clk6x)
    begin
        if (rst)
        begin
            phi2_last = 1'b0;
        end
        else
        begin
            if (phi2_last && !cphi2)
            begin
                bus_q.push_back({cpu_ab, cpu_db, cpu_status}); // Cycle just traced
                draw_bus_values();
            end
            phi2_last = cphi2;
        end
    end

    task automatic wait_reset_done();
        int ticks;
        ticks = 0;
        @(negedge clk6x);
        while (rst)
        begin
            @(negedge clk6x);
            ticks++;
            if (ticks > TIMEOUT)
            begin
                fail_now("timeout waiting for reset release");
            end
        end
    endtask

    task automatic wait_stopped(input logic level, input string what);
        int ticks;
        ticks = 0;
        while (stopped !== level)
        begin
            @(negedge clk6x);
            ticks++;
            if (ticks > TIMEOUT)
            begin
                fail_now($sformatf("timeout waiting for %s", what));
            end
        end
    endtask

    task automatic wait_phi2_rises(input int count, input string what);
        int   ticks;
        int   seen;
        logic last;
        ticks = 0;
        seen  = 0;
        last  = cphi2;
        while (seen < count)
        begin
            @(negedge clk6x);
            ticks++;
            if (cphi2 && !last)
            begin
                seen++;
            end
            last = cphi2;
            if (ticks > TIMEOUT)
            begin
                fail_now($sformatf("timeout waiting for %s", what));
            end
        end
    endtask

    // Strobe lasts one clock, returns on the next falling edge
    task automatic send_cmd(input icd_cmd_e op, input logic reply);
        int ticks;
        ticks = 0;
        while (busy)
        begin
            @(negedge clk6x);
            ticks++;
            if (ticks > TIMEOUT)
            begin
                fail_now("timeout waiting for the host port to go idle");
            end
        end
        expect_rx = reply;
        cmd       = op;
        cmd_valid = 1'b1;
        @(negedge clk6x);
        cmd_valid = 1'b0;
    endtask

    task automatic collect_bytes(input int count);
        int ticks;
        int got;
        ticks = 0;
        got   = 0;
        while (got < count)
        begin
            if (rd_valid)
            begin
                rx_bytes[got] = rd_byte;
                got++;
            end
            if (got < count)
            begin
                @(negedge clk6x);
                ticks++;
                if (ticks > TIMEOUT)
                begin
                    fail_now("timeout waiting for a reply byte on the host port");
                end
            end
        end
        @(negedge clk6x);       // Last byte off the port
        expect_rx = 1'b0;
    endtask

    task automatic check_status(input string test, input logic [7:0] expected);
        send_cmd(CMD_STATUS, 1'b1);
        collect_bytes(1);
        check_value(test, expected, rx_bytes[0]);
    endtask

    task automatic read_record(input string test);
        logic [31:0] cyc;
        logic [7:0]  exp_bytes [TRACE_BYTES];
        if (bus_q.size() == 0)
        begin
            fail_now("record read with no bus cycle left in the model queue");
        end
        cyc          = bus_q.pop_front();
        exp_bytes[0] = cyc[31:24];     // Address high
        exp_bytes[1] = cyc[23:16];
        exp_bytes[2] = cyc[15:8];      // Data
        exp_bytes[3] = next_seq;
        exp_bytes[4] = cyc[7:0];       // Status pins
        send_cmd(CMD_READ, 1'b1);
        collect_bytes(TRACE_BYTES);
        for (int i = 0; i < TRACE_BYTES; i++)
        begin
            check_value($sformatf("%s seq %0d byte %0d", test, next_seq, i),
                        exp_bytes[i], rx_bytes[i]);
        end
        next_seq++;
    endtask

    // Empty and stopped once every traced cycle is read back
    task automatic drain_records(input string test);
        while (bus_q.size() != 0)
        begin
            read_record(test);
        end
        check_status({test, " status after drain"}, 8'h05);
    endtask

    task automatic check_quiet_port();
        repeat (QUIET_TICKS)
        begin
            check_value("empty read rd_valid_o", 1'b0, rd_valid);
            check_value("empty read busy_o", 1'b0, busy);
            @(negedge clk6x);
        end
    endtask

    a_reset_state: assert property (@(posedge clk6x)
        $fell(rst) |-> (stopped && !cphi2 && !busy && !rd_valid))
        else fail_now("DUT outputs not in their reset state after reset release");

    a_phi2_shape: assert property (@(posedge clk6x) disable iff (rst)
        $rose(cphi2) |-> cphi2 [*3] ##1 !cphi2 [*3])
        else fail_now("CPU clock is not 3 clocks high then 3 clocks low");

    // Next rise 6 clocks after the last one while cycles keep running
    a_phi2_period: assert property (@(posedge clk6x) disable iff (rst)
        $fell(cphi2) ##1 !stopped |-> ##1 !cphi2 ##1 cphi2)
        else fail_now("CPU clock period is not 6 clocks while running");

    a_phi2_running: assert property (@(posedge clk6x) disable iff (rst)
        cphi2 |-> !stopped)
        else fail_now("CPU clock high while stopped_o is high");

    a_host_quiet: assert property (@(posedge clk6x) disable iff (rst)
        (rd_valid || busy) |-> expect_rx)
        else fail_now("host port active without a pending reply");

    initial
    begin
        error_count = 0;
        next_seq    = '0;
        expect_rx   = 1'b0;
        phi2_last   = 1'b0;
        cmd_valid   = 1'b0;
        cmd         = CMD_RUN;
        draw_bus_values();
        wait_reset_done();

        // Reset state
        check_value("reset stopped_o", 1'b1, stopped);
        check_value("reset cphi2_o", 1'b0, cphi2);
        check_status("reset status", 8'h05);

        // CPU clock shape, checked by the assertions above
        send_cmd(CMD_RUN, 1'b0);
        wait_stopped(1'b0, "CPU start after CMD_RUN");
        wait_phi2_rises(3, "three CPU clock cycles");

        // Record contents
        send_cmd(CMD_STOP, 1'b0);
        wait_stopped(1'b1, "CPU stop after CMD_STOP");
        check_status("stopped status", 8'h04);   // Stopped, records held
        drain_records("record contents");

        // Back-pressure fills the FIFO and parks the CPU
        send_cmd(CMD_RUN, 1'b0);
        wait_stopped(1'b0, "CPU restart before back-pressure");
        wait_stopped(1'b1, "back-pressure stop");
        check_value("records held at full", FIFO_DEPTH, bus_q.size());
        send_cmd(CMD_STOP, 1'b0);               // Keep it parked while draining
        check_status("full status", 8'h06);
        drain_records("back-pressure");

        // Empty read, then a fresh run
        send_cmd(CMD_READ, 1'b0);
        check_quiet_port();
        send_cmd(CMD_RUN, 1'b0);
        wait_stopped(1'b0, "CPU resume after drain");
        wait_phi2_rises(2, "cycles after resume");
        send_cmd(CMD_STOP, 1'b0);
        wait_stopped(1'b1, "CPU stop after resume");
        drain_records("resume");

        if (error_count == 0)
        begin
            $display("PASS: all tests");
        end
        else
        begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* dv/tb_clkgen.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clk6x source and power-on reset
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_clkgen #(
    parameter real PERIOD_NS    = 4.0,  // clk6x period
    parameter int  RESET_CYCLES = 16
) (
    output logic clk6x,
    output logic rst_o
);

    initial
    begin
        clk6x = 1'b0;
        forever #(PERIOD_NS / 2.0) clk6x = ~clk6x;
    end

    // Released on a falling edge, like all other stimulus
    initial
    begin
        rst_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk6x);
        @(negedge clk6x);
        rst_o = 1'b0;
    end

endmodule

/* hdl/nora_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CPU-bus top: phaser, bus tracer, trace FIFO and ICD controller
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module nora_top #(
    parameter int FIFO_DEPTH = 8    // Trace records held before the CPU stalls
) (
    input  logic                         clk6x,
    input  logic                         rst_i,
    input  logic [nora_pkg::ADDR_W-1:0]  cpu_ab_i,
    input  logic [nora_pkg::DATA_W-1:0]  cpu_db_i,
    input  logic [nora_pkg::DATA_W-1:0]  cpu_status_i,
    input  logic                         cmd_valid_i,
    input  nora_pkg::icd_cmd_e           cmd_i,
    output logic                         cphi2_o,
    output logic                         stopped_o,
    output logic                         busy_o,
    output logic [nora_pkg::DATA_W-1:0]  rd_byte_o,
    output logic                         rd_valid_o
);

    logic                          run;
    logic                          latch_ad;
    logic                          setup_cs;
    logic                          release_wr;
    logic                          push;
    logic [nora_pkg::TRACE_W-1:0]  rec;
    logic [nora_pkg::TRACE_W-1:0]  rd_rec;
    logic                          empty;
    logic                          full;
    logic                          pop;

    cpu_phaser u_phaser (
        .clk6x        (clk6x),
        .rst_i        (rst_i),
        .run_i        (run),
        .stopped_o    (stopped_o),
        .cphi2_o      (cphi2_o),
        .latch_ad_o   (latch_ad),
        .setup_cs_o   (setup_cs),
        .release_wr_o (release_wr),
        .release_cs_o ()                // No memory bus here
    );

    bus_tracer u_tracer (
        .clk6x        (clk6x),
        .rst_i        (rst_i),
        .cpu_ab_i     (cpu_ab_i),
        .cpu_db_i     (cpu_db_i),
        .cpu_status_i (cpu_status_i),
        .latch_ad_i   (latch_ad),
        .setup_cs_i   (setup_cs),
        .release_wr_i (release_wr),
        .rec_o        (rec),
        .push_o       (push)
    );

    trace_fifo #(
        .DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk6x    (clk6x),
        .rst_i    (rst_i),
        .push_i   (push),
        .wr_rec_i (rec),
        .pop_i    (pop),
        .rd_rec_o (rd_rec),
        .empty_o  (empty),
        .full_o   (full)
    );

    icd_controller u_icd (
        .clk6x       (clk6x),
        .rst_i       (rst_i),
        .cmd_valid_i (cmd_valid_i),
        .cmd_i       (cmd_i),
        .rd_rec_i    (rd_rec),
        .empty_i     (empty),
        .full_i      (full),
        .stopped_i   (stopped_o),
        .pop_o       (pop),
        .run_o       (run),
        .busy_o      (busy_o),
        .rd_byte_o   (rd_byte_o),
        .rd_valid_o  (rd_valid_o)
    );

endmodule

/* hdl/icd_controller.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ICD controller: host command decode, CPU run request, record readout
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module icd_controller
    import nora_pkg::*;
(
    input  logic               clk6x,
    input  logic               rst_i,
    input  logic               cmd_valid_i,    // One-clock command strobe
    input  icd_cmd_e           cmd_i,
    input  logic [TRACE_W-1:0] rd_rec_i,       // FIFO head
    input  logic               empty_i,
    input  logic               full_i,
    input  logic               stopped_i,
    output logic               pop_o,
    output logic               run_o,          // To phaser
    output logic               busy_o,
    output logic [DATA_W-1:0]  rd_byte_o,
    output logic               rd_valid_o
);

    localparam int SHIFT_W = TRACE_W - DATA_W;     // Bytes left after the first
    localparam int CNT_W   = $clog2(TRACE_BYTES);

    logic               run_req_q;      // Host run request
    logic               busy_q;
    logic               pop_q;
    logic               rd_valid_q;
    logic               stat_q;         // Current byte is a status reply
    logic [CNT_W-1:0]   cnt_q;          // Record bytes still to send
    logic [SHIFT_W-1:0] shift_q;
    logic [DATA_W-1:0]  rd_byte_q;
    logic               accept;
    logic               do_status;
    logic               do_read;
    logic               sending;
    logic [DATA_W-1:0]  status_byte;

    assign accept      = cmd_valid_i && !busy_q;       // Dropped while busy
    assign do_status   = accept && (cmd_i == CMD_STATUS);
    assign do_read     = accept && (cmd_i == CMD_READ) && !empty_i;  // Empty read is silent
    assign sending     = (cnt_q != '0);
    assign status_byte = {{(DATA_W - 3){1'b0}}, stopped_i, full_i, empty_i};

    // Run request, cleared at reset
    always_ff @(posedge clk6x)
    begin
        if (rst_i)
        begin
            run_req_q <= 1'b0;
        end
        else if (accept)
        begin
            case (cmd_i)
                CMD_RUN:  run_req_q <= 1'b1;
                CMD_STOP: run_req_q <= 1'b0;
                default:  run_req_q <= run_req_q;
            endcase
        end
    end

    // Full gates the CPU here and nowhere else
    assign run_o = run_req_q && !full_i;

    // Response sequencing
    always_ff @(posedge clk6x)
    begin
        if (rst_i)
        begin
            busy_q     <= 1'b0;
            pop_q      <= 1'b0;
            rd_valid_q <= 1'b0;
            stat_q     <= 1'b0;
            cnt_q      <= '0;
        end
        else
        begin
            pop_q      <= do_read;                          // Pop with the first byte
            stat_q     <= do_status;
            rd_valid_q <= do_status || do_read || sending;
            busy_q     <= do_read || sending;               // Covers all five bytes
            if (do_read)
            begin
                cnt_q <= CNT_W'(TRACE_BYTES - 1);
            end
            else if (sending)
            begin
                cnt_q <= cnt_q - 1'b1;
            end
        end
    end

    // Byte shifter, MSB first
    always_ff @(posedge clk6x)
    begin
        if (do_read)
        begin
            rd_byte_q <= rd_rec_i[TRACE_W-1 -: DATA_W];    // Address high
            shift_q   <= rd_rec_i[SHIFT_W-1:0];
        end
        else if (do_status)
        begin
            rd_byte_q <= status_byte;
        end
        else if (sending)
        begin
            rd_byte_q <= shift_q[SHIFT_W-1 -: DATA_W];
            shift_q   <= shift_q << DATA_W;
        end
    end

    assign pop_o      = pop_q;
    assign busy_o     = busy_q;
    assign rd_byte_o  = rd_byte_q;
    assign rd_valid_o = rd_valid_q;

    // Every output byte belongs to a record burst or a status reply
    a_valid_owner: assert property (@(posedge clk6x) disable iff (rst_i)
        rd_valid_o |-> (busy_o || stat_q));

    // Popped record leaves as one unbroken burst, then the port frees up
    a_read_burst: assert property (@(posedge clk6x) disable iff (rst_i)
        pop_o |-> rd_valid_o [*TRACE_BYTES] ##1 !busy_o);

endmodule

/* hdl/trace_fifo.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Trace record FIFO with registered full and empty levels
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module trace_fifo
    import nora_pkg::*;
#(
    parameter int DEPTH = 8         // Power of two, 2 or more
) (
    input  logic               clk6x,
    input  logic               rst_i,
    input  logic               push_i,
    input  logic [TRACE_W-1:0] wr_rec_i,
    input  logic               pop_i,
    output logic [TRACE_W-1:0] rd_rec_o,   // Head record
    output logic               empty_o,
    output logic               full_o
);

    localparam int PTR_W = $clog2(DEPTH);

    logic [TRACE_W-1:0] mem_q [DEPTH];
    logic [PTR_W-1:0]   wr_ptr_q;
    logic [PTR_W-1:0]   rd_ptr_q;
    logic [PTR_W:0]     count_q;       // One extra bit for DEPTH itself
    logic [PTR_W:0]     count_d;
    logic               empty_q;
    logic               full_q;

    if ((DEPTH < 2) || ((DEPTH & (DEPTH - 1)) != 0))
    begin : g_bad_depth
        $error("trace_fifo DEPTH must be a power of two, 2 or more");
    end

    always_comb
    begin
        count_d = count_q;
        if (push_i && !pop_i)
        begin
            count_d = count_q + 1'b1;
        end
        else if (pop_i && !push_i)
        begin
            count_d = count_q - 1'b1;
        end
    end

    // Storage
    always_ff @(posedge clk6x)
    begin
        if (push_i)
        begin
            mem_q[wr_ptr_q] <= wr_rec_i;
        end
    end

    // Pointers wrap naturally
    always_ff @(posedge clk6x)
    begin
        if (rst_i)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            empty_q  <= 1'b1;
            full_q   <= 1'b0;
        end
        else
        begin
            if (push_i)
            begin
                wr_ptr_q <= wr_ptr_q + PTR_W'(1);
            end
            if (pop_i)
            begin
                rd_ptr_q <= rd_ptr_q + PTR_W'(1);
            end
            count_q <= count_d;
            empty_q <= (count_d == '0);
            full_q  <= (count_d == (PTR_W + 1)'(DEPTH));
        end
    end

    assign rd_rec_o = mem_q[rd_ptr_q];
    assign empty_o  = empty_q;
    assign full_o   = full_q;

    // Back-pressure must stop the CPU before another record arrives
    a_no_push_full: assert property (@(posedge clk6x) disable iff (rst_i)
        push_i |-> !full_o);

    a_no_pop_empty: assert property (@(posedge clk6x) disable iff (rst_i)
        pop_i |-> !empty_o);

endmodule

/* hdl/bus_tracer.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CPU bus tracer: one 40-bit record per bus cycle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module bus_tracer
    import nora_pkg::*;
(
    input  logic               clk6x,
    input  logic               rst_i,
    input  logic [ADDR_W-1:0]  cpu_ab_i,
    input  logic [DATA_W-1:0]  cpu_db_i,
    input  logic [DATA_W-1:0]  cpu_status_i,   // Status pins, one byte
    input  logic               latch_ad_i,
    input  logic               setup_cs_i,
    input  logic               release_wr_i,
    output logic [TRACE_W-1:0] rec_o,
    output logic               push_o
);

    logic [ADDR_W-1:0] ab_q;        // Address at latch_ad
    logic [DATA_W-1:0] status_q;    // Status pins at latch_ad
    logic [DATA_W-1:0] db_q;        // Data at release_wr
    logic [DATA_W-1:0] seq_q;       // Record sequence, wraps at 256
    logic              push_q;
    logic              win_q;       // Capture window, setup_cs to release_wr

    // Bus payload
    always_ff @(posedge clk6x)
    begin
        if (latch_ad_i)
        begin
            ab_q     <= cpu_ab_i;
            status_q <= cpu_status_i;
        end
        if (release_wr_i)
        begin
            db_q <= cpu_db_i;       // Data valid late in the cycle
        end
    end

    // Push, sequence and window control
    always_ff @(posedge clk6x)
    begin
        if (rst_i)
        begin
            push_q <= 1'b0;
            seq_q  <= '0;
            win_q  <= 1'b0;
        end
        else
        begin
            push_q <= release_wr_i;             // One clock after data capture
            if (push_q)
            begin
                seq_q <= seq_q + 1'b1;          // Next record number
            end
            if (setup_cs_i)
            begin
                win_q <= 1'b1;
            end
            else if (release_wr_i)
            begin
                win_q <= 1'b0;
            end
        end
    end

    assign rec_o  = {ab_q, db_q, seq_q, status_q};
    assign push_o = push_q;

    // Data sampled only inside an opened access
    a_wr_in_window: assert property (@(posedge clk6x) disable iff (rst_i)
        release_wr_i |-> win_q);

endmodule

/* hdl/cpu_phaser.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CPU cycle phaser: phase counter, CPU clock and bus phase strobes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module cpu_phaser
    import nora_pkg::*;
(
    input  logic clk6x,
    input  logic rst_i,
    input  logic run_i,          // Run level from ICD
    output logic stopped_o,      // No CPU cycle in progress
    output logic cphi2_o,        // CPU clock
    output logic latch_ad_o,     // PH_1
    output logic setup_cs_o,     // PH_2
    output logic release_wr_o,   // PH_4
    output logic release_cs_o    // PH_5
);

    phase_e phase_q;
    phase_e phase_d;
    logic   stopped_q;
    logic   stopped_d;
    logic   running_d;

    // Run level is sampled as a cycle opens in PH_0, so a record pushed
    // in PH_5 is already reflected in the FIFO full level at that point
    always_comb
    begin
        phase_d   = phase_q;
        stopped_d = stopped_q;
        if (stopped_q)
        begin
            stopped_d = !run_i;                 // Parked in PH_0, restart there
        end
        else if ((phase_q == PH_0) && !run_i)
        begin
            stopped_d = 1'b1;                   // Park before any strobe
        end
        else
        begin
            case (phase_q)
                PH_0:    phase_d = PH_1;
                PH_1:    phase_d = PH_2;
                PH_2:    phase_d = PH_3;
                PH_3:    phase_d = PH_4;
                PH_4:    phase_d = PH_5;
                default: phase_d = PH_0;        // PH_5 wraps
            endcase
        end
    end

    assign running_d = !stopped_d;

    // Outputs decoded from next phase, so they line up with phase_q
    always_ff @(posedge clk6x)
    begin
        if (rst_i)
        begin
            phase_q      <= PH_0;
            stopped_q    <= 1'b1;
            cphi2_o      <= 1'b0;
            latch_ad_o   <= 1'b0;
            setup_cs_o   <= 1'b0;
            release_wr_o <= 1'b0;
            release_cs_o <= 1'b0;
        end
        else
        begin
            phase_q      <= phase_d;
            stopped_q    <= stopped_d;
            cphi2_o      <= running_d && (phase_d inside {PH_3, PH_4, PH_5});
            latch_ad_o   <= running_d && (phase_d == PH_1);
            setup_cs_o   <= running_d && (phase_d == PH_2);
            release_wr_o <= running_d && (phase_d == PH_4);
            release_cs_o <= running_d && (phase_d == PH_5);
        end
    end

    assign stopped_o = stopped_q;

    // CPU held quiet while parked
    a_quiet_when_stopped: assert property (@(posedge clk6x) disable iff (rst_i)
        stopped_o |-> !(cphi2_o || latch_ad_o || setup_cs_o || release_wr_o || release_cs_o));

endmodule

/* hdl/nora_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared widths, CPU cycle phase enum and ICD host opcode enum
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package nora_pkg;

    // CPU bus widths
    localparam int ADDR_W      = 16;    // 65xx address bus
    localparam int DATA_W      = 8;     // Data bus, also one host byte

    // Trace record, MSB first on the host port
    //   [39:24] address, [23:16] data, [15:8] sequence, [7:0] status pins
    localparam int TRACE_W     = 40;
    localparam int TRACE_BYTES = 5;     // TRACE_W / DATA_W

    // Six clk6x ticks per CPU cycle
    typedef enum logic [2:0] {
        PH_0 = 3'd0,    // CPU clock low
        PH_1 = 3'd1,    // Address latch
        PH_2 = 3'd2,    // Chip-select setup
        PH_3 = 3'd3,    // CPU clock high from here
        PH_4 = 3'd4,    // Write release, data sampled
        PH_5 = 3'd5     // Cycle end
    } phase_e;

    // Host commands
    typedef enum logic [1:0] {
        CMD_RUN    = 2'd0,  // Set run request
        CMD_STOP   = 2'd1,  // Clear run request
        CMD_STATUS = 2'd2,  // One status byte
        CMD_READ   = 2'd3   // Pop one record as five bytes
    } icd_cmd_e;

endpackage
